// File: source/codec_cmd_rom.sv
`timescale 1ns/1ps
`default_nettype none

module codec_cmd_rom import codec_init_pkg::*; (
	input  wire logic [STEP_W-1:0] i_step,
	output codec_word_u            o_word
);

	always_comb begin
		o_word = '1;
		case (i_step)
			// the reset register clears the codec on any write
			3'd0: begin
				o_word.regs = '{addr: 7'd15, data: 9'h000};
			end
			// analog audio path
			3'd1: begin
				o_word.regs = '{addr: 7'd4, data: 9'h015};
			end
			// digital audio path
			3'd2: begin
				o_word.regs = '{addr: 7'd5, data: 9'h000};
			end
			// power down control with everything powered up
			3'd3: begin
				o_word.regs = '{addr: 7'd6, data: 9'h000};
			end
			// digital audio interface format
			3'd4: begin
				o_word.regs = '{addr: 7'd7, data: 9'h042};
			end
			// sampling control
			3'd5: begin
				o_word.regs = '{addr: 7'd8, data: 9'h019};
			end
			// activate the digital interface last
			3'd6: begin
				o_word.regs = '{addr: 7'd9, data: 9'h001};
			end
			default: begin
				o_word = '1;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/codec_init_pkg.sv
`default_nettype none

package codec_init_pkg;

	// device address of the codec, sent with the write bit cleared
	localparam logic [6:0] CODEC_DEV_ADDR = 7'h34;

	// system clocks per quarter of an SCL period
	localparam int QTR_CYCLES = 4;

	localparam int NUM_CMDS     = 7;
	localparam int MAX_ATTEMPTS = 3;
	localparam int STEP_W       = 3;

	// register view used when the command table is built
	typedef struct packed {
		logic [6:0] addr;
		logic [8:0] data;
	} codec_reg_view_t;

	// byte view used when the word is shifted onto the bus
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} codec_byte_view_t;

	typedef union packed {
		codec_reg_view_t  regs;
		codec_byte_view_t bytes;
	} codec_word_u;

	// a request is only raised while the sequencer holds the credit
	typedef struct packed {
		logic        valid;
		codec_word_u word;
	} i2c_req_t;

	// nack is meaningful only in the cycle where credit is high
	typedef struct packed {
		logic credit;
		logic nack;
	} i2c_rsp_t;

endpackage

`default_nettype wire

// File: source/codec_init_seq.sv
`timescale 1ns/1ps
`default_nettype none

module codec_init_seq import codec_init_pkg::*; (
	input  wire logic              i_clk,
	input  wire logic              i_rst_n,
	input  wire logic              i_start,
	input  wire i2c_rsp_t          i_rsp,
	input  wire codec_word_u       i_word,
	output logic [STEP_W-1:0]      o_step,
	output i2c_req_t               o_req,
	output logic                   o_fin,
	output logic                   o_error
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_WAIT,
		S_DONE
	} state_e;

	typedef logic [$clog2(MAX_ATTEMPTS)-1:0] attempt_t;

	state_e      state_r;
	logic [1:0]  credit_r;
	logic [STEP_W-1:0] step_r;
	attempt_t    attempt_r;
	logic        spend;

	// a request always spends the single credit
	assign spend  = (state_r == S_ISSUE) && (credit_r != 2'd0);
	assign o_req  = '{valid: spend, word: i_word};
	assign o_step = step_r;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r   <= S_IDLE;
			credit_r  <= 2'd1;
			step_r    <= '0;
			attempt_r <= '0;
			o_fin     <= 1'b0;
			o_error   <= 1'b0;
		end else begin
			credit_r <= credit_r + {1'b0, i_rsp.credit} - {1'b0, spend};
			case (state_r)
				S_IDLE, S_DONE: begin
					if (i_start) begin
						step_r    <= '0;
						attempt_r <= '0;
						o_fin     <= 1'b0;
						o_error   <= 1'b0;
						state_r   <= S_ISSUE;
					end
				end
				S_ISSUE: begin
					if (spend) begin
						state_r <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (i_rsp.credit) begin
						if (!i_rsp.nack) begin
							attempt_r <= '0;
							if (step_r == STEP_W'(NUM_CMDS - 1)) begin
								o_fin   <= 1'b1;
								state_r <= S_DONE;
							end else begin
								step_r  <= step_r + 1'b1;
								state_r <= S_ISSUE;
							end
						end else if (attempt_r == attempt_t'(MAX_ATTEMPTS - 1)) begin
							// the retries are used up and the whole sequence stops
							o_fin   <= 1'b1;
							o_error <= 1'b1;
							state_r <= S_DONE;
						end else begin
							attempt_r <= attempt_r + 1'b1;
							state_r   <= S_ISSUE;
						end
					end
				end
				default: begin
					state_r <= S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/codec_init_top.sv
`timescale 1ns/1ps
`default_nettype none

module codec_init_top import codec_init_pkg::*; (
	input  wire i_clk,
	input  wire i_rst_n,
	input  wire i_start,
	output wire o_fin,
	output wire o_error,
	output wire o_scl,
	inout  wire io_sda
);

	i2c_req_t          seq_req;
	i2c_rsp_t          eng_rsp;
	codec_word_u       rom_word;
	logic [STEP_W-1:0] step;

	codec_init_seq seq_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_start (i_start),
		.i_rsp   (eng_rsp),
		.i_word  (rom_word),
		.o_step  (step),
		.o_req   (seq_req),
		.o_fin   (o_fin),
		.o_error (o_error)
	);

	codec_cmd_rom rom_i (
		.i_step (step),
		.o_word (rom_word)
	);

	i2c_write_engine eng_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_req   (seq_req),
		.o_rsp   (eng_rsp),
		.o_scl   (o_scl),
		.io_sda  (io_sda)
	);

endmodule

`default_nettype wire

// File: source/i2c_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_write_engine import codec_init_pkg::*; (
	input  wire logic     i_clk,
	input  wire logic     i_rst_n,
	input  wire i2c_req_t i_req,
	output i2c_rsp_t      o_rsp,
	output logic          o_scl,
	inout  wire           io_sda
);

	typedef enum logic [2:0] {
		P_IDLE,
		P_START,
		P_BIT,
		P_PREP,
		P_STOP,
		P_FREE
	} phase_e;

	typedef logic [$clog2(QTR_CYCLES)-1:0] qcnt_t;

	phase_e      phase_r;
	qcnt_t       qcnt_r;
	logic [1:0]  qtr_r;
	logic [4:0]  bit_r;
	logic [23:0] shift_r;
	logic        scl_r;
	logic        sda_r;
	logic        nack_r;
	logic        credit_r;
	logic        tick;
	logic        ack_slot;
	logic        last_slot;

	// sda_r high means the line is released to the pullup
	assign io_sda = sda_r ? 1'bz : 1'b0;
	assign o_scl  = scl_r;
	assign o_rsp  = '{credit: credit_r, nack: nack_r};

	assign tick = (phase_r != P_IDLE) && (qcnt_r == qcnt_t'(QTR_CYCLES - 1));

	// a transaction has 27 slots and an acknowledge follows every eighth bit
	assign ack_slot  = (bit_r == 5'd8) || (bit_r == 5'd17) || (bit_r == 5'd26);
	assign last_slot = (bit_r == 5'd26);

	always_ff @(posedge i_clk) begin
		if (phase_r == P_IDLE && i_req.valid) begin
			shift_r <= {CODEC_DEV_ADDR, 1'b0, i_req.word.bytes.hi, i_req.word.bytes.lo};
		end else if (phase_r == P_BIT && tick && qtr_r == 2'd3 && !ack_slot) begin
			shift_r <= shift_r << 1;
		end
	end

	// within each SCL period quarters 0 and 1 are low and quarters 2 and 3 are high
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase_r  <= P_IDLE;
			qcnt_r   <= '0;
			qtr_r    <= '0;
			bit_r    <= '0;
			scl_r    <= 1'b1;
			sda_r    <= 1'b1;
			nack_r   <= 1'b0;
			credit_r <= 1'b0;
		end else begin
			credit_r <= 1'b0;
			if (phase_r == P_IDLE) begin
				qcnt_r <= '0;
				qtr_r  <= '0;
				if (i_req.valid) begin
					phase_r <= P_START;
					bit_r   <= '0;
					nack_r  <= 1'b0;
				end
			end else begin
				qcnt_r <= tick ? '0 : qcnt_r + 1'b1;
				if (tick) begin
					qtr_r <= qtr_r + 1'b1;
					case (phase_r)
						P_START: begin
							// SDA falls while SCL is still high
							case (qtr_r)
								2'd0: sda_r <= 1'b0;
								2'd2: scl_r <= 1'b0;
								2'd3: phase_r <= P_BIT;
								default: begin
								end
							endcase
						end
						P_BIT: begin
							case (qtr_r)
								2'd0: sda_r <= ack_slot ? 1'b1 : shift_r[23];
								2'd1: scl_r <= 1'b1;
								2'd2: begin
									// middle of the high phase
									if (ack_slot) begin
										nack_r <= nack_r | io_sda;
									end
								end
								2'd3: begin
									scl_r <= 1'b0;
									bit_r <= bit_r + 1'b1;
									if (last_slot) begin
										phase_r <= P_PREP;
									end
								end
								default: begin
								end
							endcase
						end
						P_PREP: begin
							// pull SDA low under a low SCL so STOP can rise
							if (qtr_r == 2'd0) begin
								sda_r <= 1'b0;
							end else if (qtr_r == 2'd3) begin
								phase_r <= P_STOP;
							end
						end
						P_STOP: begin
							case (qtr_r)
								2'd0: scl_r <= 1'b1;
								2'd1: sda_r <= 1'b1;
								2'd3: phase_r <= P_FREE;
								default: begin
								end
							endcase
						end
						P_FREE: begin
							// one idle period of bus free time before the next START
							if (qtr_r == 2'd3) begin
								phase_r  <= P_IDLE;
								credit_r <= 1'b1;
							end
						end
						default: begin
							phase_r <= P_IDLE;
						end
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: tb.f
source/codec_init_pkg.sv
source/codec_cmd_rom.sv
source/i2c_write_engine.sv
source/codec_init_seq.sv
source/codec_init_top.sv
verif/i2c_codec_model.sv
verif/codec_init_asserts.sv
verif/tb_codec_init.sv

// File: verif/codec_init_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module codec_init_asserts (
	input wire logic i_clk,
	input wire logic i_rst_n,
	input wire logic i_scl,
	input wire logic i_sda,
	input wire logic i_in_bit,
	input wire logic i_idle,
	input wire logic i_req_valid,
	input wire logic i_credit
);

	// high from a request until its credit comes back
	logic busy_r;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy_r <= 1'b0;
		end else if (i_req_valid) begin
			busy_r <= 1'b1;
		end else if (i_credit) begin
			busy_r <= 1'b0;
		end
	end

	a_sda_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_in_bit && i_scl && $past(i_scl)) |-> $stable(i_sda))
		else $error("SDA changed while SCL was high inside a byte");

	a_req_credit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_req_valid |-> (!busy_r && i_idle))
		else $error("request arrived while the sequencer held no credit");

	// a second credit would only appear if one came back without a request
	a_credit_one: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_credit |-> busy_r)
		else $error("credit returned without an outstanding request");

endmodule

bind i2c_write_engine codec_init_asserts asserts_i (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_scl       (o_scl),
	.i_sda       (io_sda),
	.i_in_bit    (phase_r == P_BIT),
	.i_idle      (phase_r == P_IDLE),
	.i_req_valid (i_req.valid),
	.i_credit    (o_rsp.credit)
);

`default_nettype wire

// File: verif/i2c_codec_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_codec_model (
	input  wire logic       i_scl,
	inout  wire             io_sda,
	input  wire logic       i_refuse_once,
	input  wire logic       i_refuse_always,
	input  wire logic [2:0] i_refuse_step
);

	// each entry is the address byte followed by the two data bytes
	logic [23:0] rec_mem [0:31];
	int          rec_cnt = 0;
	int          ok_cnt = 0;
	int          refused_cnt = 0;
	int          slot = 0;
	logic [23:0] shift = '0;
	logic        in_frame = 1'b0;
	logic        refuse = 1'b0;
	logic        pull_low = 1'b0;

	assign io_sda = pull_low ? 1'b0 : 1'bz;

	task automatic clear_log();
		rec_cnt = 0;
		ok_cnt = 0;
		refused_cnt = 0;
	endtask

	// START is SDA falling while SCL is high
	always @(negedge io_sda) begin
		if (i_scl === 1'b1) begin
			in_frame = 1'b1;
			slot = 0;
			shift = '0;
			refuse = (i_refuse_always || (i_refuse_once && refused_cnt == 0))
				&& (ok_cnt == int'(i_refuse_step));
		end
	end

	// STOP is SDA rising while SCL is high
	always @(posedge io_sda) begin
		if (i_scl === 1'b1 && in_frame) begin
			in_frame = 1'b0;
			if (rec_cnt < 32) begin
				rec_mem[rec_cnt] = shift;
			end
			rec_cnt++;
			if (refuse) begin
				refused_cnt++;
			end else begin
				ok_cnt++;
			end
		end
	end

	// data sits in the slots below 26 except the acknowledge slots 8 and 17
	always @(posedge i_scl) begin
		if (in_frame) begin
			if (slot < 26 && slot != 8 && slot != 17) begin
				shift = {shift[22:0], io_sda};
			end
			slot++;
		end
	end

	// the refusal is given on the last acknowledge once the word is known
	always @(negedge i_scl) begin
		if (in_frame) begin
			if (slot == 8 || slot == 17) begin
				pull_low = 1'b1;
			end else if (slot == 26) begin
				pull_low = !refuse;
			end else begin
				pull_low = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_codec_init.sv
`timescale 1ns/1ps
`default_nettype none

module tb_codec_init import codec_init_pkg::*; ();

	typedef enum logic [1:0] {
		NACK_NONE,
		NACK_ONCE,
		NACK_ALWAYS
	} nack_mode_e;

	logic clk = 1'b0;
	logic rst_n;
	logic start;
	wire  fin;
	wire  err;
	wire  scl;
	wire  sda;
	logic refuse_once;
	logic refuse_always;
	logic [2:0] refuse_step;

	string       row_name [0:7];
	nack_mode_e  row_mode [0:7];
	int          row_step [0:7];
	logic        row_rand [0:7];
	logic [15:0] exp_word [0:6];
	int          exp_step [0:31];
	int          exp_cnt;
	logic        exp_err;
	logic [16:0] lfsr_r;

	pullup (sda);

	always #5 clk = ~clk;

	codec_init_top dut_i (
		.i_clk   (clk),
		.i_rst_n (rst_n),
		.i_start (start),
		.o_fin   (fin),
		.o_error (err),
		.o_scl   (scl),
		.io_sda  (sda)
	);

	i2c_codec_model model_i (
		.i_scl           (scl),
		.io_sda          (sda),
		.i_refuse_once   (refuse_once),
		.i_refuse_always (refuse_always),
		.i_refuse_step   (refuse_step)
	);

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			$display("FAILED %s expected %0h actual %0h", name, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// taps 17 and 14 give a maximal length sequence
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task pick_step(output int k);
		logic [2:0] v;
		v = '0;
		for (int i = 0; i < 3; i++) begin
			lfsr_r = lfsr_next(lfsr_r);
			v = {v[1:0], lfsr_r[0]};
		end
		k = int'(v) % 7;
	endtask

	task automatic set_row(input int r, input string name, input nack_mode_e mode,
			input int step, input logic rnd);
		row_name[r] = name;
		row_mode[r] = mode;
		row_step[r] = step;
		row_rand[r] = rnd;
	endtask

	task load_table();
		set_row(0, "clean_run", NACK_NONE, 0, 1'b0);
		set_row(1, "nack_once_random", NACK_ONCE, 0, 1'b1);
		set_row(2, "nack_once_first", NACK_ONCE, 0, 1'b0);
		set_row(3, "nack_once_last", NACK_ONCE, 6, 1'b0);
		set_row(4, "nack_always_4", NACK_ALWAYS, 4, 1'b0);
		set_row(5, "restart_clean", NACK_NONE, 0, 1'b0);
		set_row(6, "nack_always_random", NACK_ALWAYS, 0, 1'b1);
		set_row(7, "restart_final", NACK_NONE, 0, 1'b0);
		// register number sits in the upper 7 bits and data in the lower 9
		exp_word[0] = {7'd15, 9'h000};
		exp_word[1] = {7'd4, 9'h015};
		exp_word[2] = {7'd5, 9'h000};
		exp_word[3] = {7'd6, 9'h000};
		exp_word[4] = {7'd7, 9'h042};
		exp_word[5] = {7'd8, 9'h019};
		exp_word[6] = {7'd9, 9'h001};
	endtask

	task automatic build_expected(input nack_mode_e mode, input int k);
		int last;
		int repeats;
		last = (mode == NACK_ALWAYS) ? k : NUM_CMDS - 1;
		exp_cnt = 0;
		for (int s = 0; s <= last; s++) begin
			repeats = 1;
			if (s == k && mode == NACK_ONCE) begin
				repeats = 2;
			end else if (s == k && mode == NACK_ALWAYS) begin
				repeats = MAX_ATTEMPTS;
			end
			repeat (repeats) begin
				exp_step[exp_cnt] = s;
				exp_cnt++;
			end
		end
		exp_err = (mode == NACK_ALWAYS);
	endtask

	task automatic run_row(input int row);
		int    k;
		string name;
		name = row_name[row];
		k = row_step[row];
		if (row_rand[row]) begin
			pick_step(k);
		end
		build_expected(row_mode[row], k);
		$display("row %s, nack step %0d", name, k);
		model_i.clear_log();
		@(posedge clk);
		refuse_once <= (row_mode[row] == NACK_ONCE);
		refuse_always <= (row_mode[row] == NACK_ALWAYS);
		refuse_step <= k[2:0];
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		check_value({name, " fin cleared"}, 0, fin);
		check_value({name, " error cleared"}, 0, err);
		while (fin !== 1'b1) begin
			@(negedge clk);
		end
		check_value({name, " error"}, exp_err, err);
		check_value({name, " count"}, exp_cnt, model_i.rec_cnt);
		for (int i = 0; i < exp_cnt; i++) begin
			// the address byte is 0x34 shifted up with the write bit clear
			check_value($sformatf("%s entry %0d", name, i),
				{8'h68, exp_word[exp_step[i]]}, model_i.rec_mem[i]);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		refuse_once = 1'b0;
		refuse_always = 1'b0;
		refuse_step = '0;
		lfsr_r = 17'd84313;
		load_table();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("idle scl", 1, scl);
		check_value("idle sda", 1, sda);
		check_value("idle fin", 0, fin);
		check_value("idle error", 0, err);
		check_value("idle records", 0, model_i.rec_cnt);
		for (int row = 0; row < $size(row_mode); row++) begin
			run_row(row);
		end
		$display("test passed");
		$finish;
	end

	// worst case per row is every command tried MAX_ATTEMPTS times at 31 SCL periods each
	initial begin
		longint limit_ns;
		limit_ns = 64'd2000 + longint'($size(row_mode))
			* (NUM_CMDS * MAX_ATTEMPTS * 31 * 4 * QTR_CYCLES * 10 + 1000);
		#(limit_ns);
		$display("ERROR: watchdog expired before all rows finished");
		$display("test failed");
		$fatal(1);
	end

endmodule

`default_nettype wire
